// File: verilog/simdSub_params.svh
// lane geometry shared by the subtractor packages and RTL, pulled in with `include
`ifndef SIMDSUB_PARAMS_SVH
`define SIMDSUB_PARAMS_SVH

// bits per lane, one prefix subtractor each
`define LANE_WIDTH 8

// lanes per request word
`define LANE_COUNT 4

// full request word
`define WORD_WIDTH (`LANE_WIDTH * `LANE_COUNT)

`endif

// File: verilog/lauPkg.sv
// arithmetic structure choices for the prefix networks, referenced as lauPkg::name

package lauPkg;

	// prefix network style, trades depth against area
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // serial chain, n-1 levels
		MEDIUM = 2'b01, // brent-kung, 2*log2(n)-1 levels
		FAST   = 2'b10  // sklansky, log2(n) levels
	} speed_e;

	// 2'b11 not a legal structure

endpackage

// File: verilog/simdSubPkg.sv
// datapath types of the packed-lane subtractor, referenced as simdSubPkg::name
`include "simdSub_params.svh"

package simdSubPkg;

	// lane mode
	typedef enum logic [1:0] {
		SUB_PACKED = 2'd0, // four separate lane differences
		SUB_WIDE   = 2'd1, // one word difference, borrow rippled
		SBB_WIDE   = 2'd2  // word difference minus borrowIn
	} subOp_e;

	// request as seen on the top ports
	typedef struct packed {
		subOp_e                 op;
		logic [`WORD_WIDTH-1:0] a;        // minuend
		logic [`WORD_WIDTH-1:0] b;        // subtrahend
		logic                   borrowIn; // only honoured in SBB_WIDE
	} subReq_t;

	// operands of one lane after the splitter register
	typedef struct packed {
		logic [`LANE_WIDTH-1:0] a;
		logic [`LANE_WIDTH-1:0] b;
		logic                   chained; // take neighbour borrow
	} laneIn_t;

	// lane register contents
	typedef struct packed {
		logic [`LANE_WIDTH-1:0] diff;
		logic                   overflow;
		logic                   zero;
		logic                   borrow; // borrow out of the lane msb
	} laneOut_t;

	// merged output
	typedef struct packed {
		logic [`WORD_WIDTH-1:0] diff;
		logic [`LANE_COUNT-1:0] laneOverflow; // raw per-lane flags
		logic [`LANE_COUNT-1:0] laneZero;
		logic                   overflow;     // wide flags
		logic                   zero;
		logic                   borrowOut;
	} subResult_t;

endpackage

// File: verilog/prefixAndOr.sv
// group generate/propagate prefix network used by subVZ, structure fixed by the speed parameter
`timescale 1ns/1ps

module prefixAndOr #(
	parameter int             width = 8,            // network width
	parameter lauPkg::speed_e speed = lauPkg::FAST  // prefix structure
) (
	input  logic [width-1:0] GI, // bit generate
	input  logic [width-1:0] PI, // bit propagate
	output logic [width-1:0] GO, // group generate over bits 0..i
	output logic [width-1:0] PO  // group propagate over bits 0..i
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	// every network below updates in place
	// a node only ever reads a node that is left alone on the same level

	if (speed == lauPkg::FAST) begin : fastPrefix
		// sklansky, every level doubles the span of all upper half-groups
		always_comb begin : sklansky
			logic [n-1:0] g;
			logic [n-1:0] p;
			int           src;
			g = GI;
			p = PI;
			src = 0;
			for (int l = 1; l <= m; l++) begin
				for (int j = 0; j < n; j++) begin
					if (((j >> (l - 1)) & 1) == 1) begin // upper half of its group
						src = ((j >> (l - 1)) << (l - 1)) - 1; // msb of lower half
						g[j] = g[j] | (p[j] & g[src]);
						p[j] = p[j] & p[src];
					end
				end
			end
			GO = g;
			PO = p;
		end
	end else if (speed == lauPkg::MEDIUM) begin : mediumPrefix
		// brent-kung, up-sweep builds the group roots
		always_comb begin : brentKung
			logic [n-1:0] g;
			logic [n-1:0] p;
			g = GI;
			p = PI;
			for (int l = 1; l <= m; l++) begin
				for (int j = 0; j < n; j++) begin
					if ((j + 1) % (1 << l) == 0) begin // root of a 2**l group
						g[j] = g[j] | (p[j] & g[j - (1 << (l - 1))]);
						p[j] = p[j] & p[j - (1 << (l - 1))];
					end
				end
			end
			// down-sweep fills in the mid points
			for (int l = m - 1; l >= 1; l--) begin
				for (int j = 0; j < n; j++) begin
					if ((j + 1) % (1 << l) == (1 << (l - 1)) && j >= (1 << l)) begin
						g[j] = g[j] | (p[j] & g[j - (1 << (l - 1))]);
						p[j] = p[j] & p[j - (1 << (l - 1))];
					end
				end
			end
			GO = g;
			PO = p;
		end
	end else begin : slowPrefix
		// serial ripple, smallest area
		always_comb begin : ripple
			logic [n-1:0] g;
			logic [n-1:0] p;
			g = GI;
			p = PI;
			for (int j = 1; j < n; j++) begin
				g[j] = g[j] | (p[j] & g[j - 1]); // j-1 already complete
				p[j] = p[j] & p[j - 1];
			end
			GO = g;
			PO = p;
		end
	end

endmodule

// File: verilog/subVZ.sv
// single-lane prefix subtractor S = A - B - CI with overflow, zero and carry-out flags
`timescale 1ns/1ps

module subVZ #(
	parameter int             width = 8,            // lane width, at least 2
	parameter lauPkg::speed_e speed = lauPkg::FAST  // prefix structure
) (
	input  logic [width-1:0] A,  // minuend
	input  logic [width-1:0] B,  // subtrahend
	input  logic             CI, // borrow in, subtracted
	output logic [width-1:0] S,  // difference
	output logic             V,  // two's complement overflow
	output logic             Z,  // zero, meaningful only for CI = 0
	output logic             CO  // carry out, inverse of borrow
);

	logic [width-1:0] bInv;   // one's complement of B
	logic             ciInv;  // carry into bit 0
	logic [width-1:0] genIn;
	logic [width-1:0] propIn; // also the sum propagate
	logic [width-1:0] genOut;
	logic [width-1:0] propOut;

	assign bInv = ~B;
	assign ciInv = ~CI;

	assign propIn = A ^ bInv;
	// bit 0 absorbs the carry-in as a majority
	assign genIn[0] = (A[0] & bInv[0]) | (A[0] & ciInv) | (bInv[0] & ciInv);
	assign genIn[width-1:1] = A[width-1:1] & bInv[width-1:1];

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix0 (
		.GI(genIn),
		.PI(propIn),
		.GO(genOut),
		.PO(propOut)
	);

	assign S = propIn ^ {genOut[width-2:0], ciInv}; // carries into each bit
	assign V = genOut[width-1] ^ genOut[width-2]; // carry into msb vs out of msb
	assign Z = propOut[width-1]; // A == B, all bits propagate
	assign CO = genOut[width-1];

endmodule

// File: verilog/operandSplitter.sv
// first pipeline stage, registers a request and slices it into per-lane operands
`timescale 1ns/1ps
`include "simdSub_params.svh"

module operandSplitter (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        reqValid,
	input  simdSubPkg::subReq_t                         req,
	output simdSubPkg::laneIn_t [`LANE_COUNT-1:0]       laneIn,
	output logic                                        firstBorrow, // lane 0 borrow in
	output logic                                        stageValid,
	output simdSubPkg::subOp_e                          stageOp
);

	// strobe register, the only control state here
	always_ff @(posedge clk) begin
		if (reset) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= reqValid;
		end
	end

	// operands load only on a request, hold otherwise
	always_ff @(posedge clk) begin
		if (reqValid) begin
			stageOp <= req.op;
			firstBorrow <= (req.op == simdSubPkg::SBB_WIDE) & req.borrowIn; // sbb only
			for (int i = 0; i < `LANE_COUNT; i++) begin
				laneIn[i].a <= req.a[i*`LANE_WIDTH +: `LANE_WIDTH];
				laneIn[i].b <= req.b[i*`LANE_WIDTH +: `LANE_WIDTH];
				laneIn[i].chained <= (req.op != simdSubPkg::SUB_PACKED); // both wide modes
			end
		end
	end

	// decode above treats 2'b11 as wide, so it must never arrive
	legalOp: assert property (@(posedge clk) disable iff (reset)
		reqValid |-> (req.op inside {simdSubPkg::SUB_PACKED, simdSubPkg::SUB_WIDE,
			simdSubPkg::SBB_WIDE}));

endmodule

// File: verilog/subLane.sv
// one subtractor lane, combinational borrow chain and a one-cycle result register
`timescale 1ns/1ps
`include "simdSub_params.svh"

module subLane #(
	parameter lauPkg::speed_e speed = lauPkg::FAST // prefix structure
) (
	input  logic                 clk,
	input  logic                 reset,
	input  simdSubPkg::laneIn_t  laneIn,
	input  logic                 borrowIn,  // from lower lane, same cycle
	output logic                 borrowOut, // to upper lane, before the register
	output simdSubPkg::laneOut_t laneOut
);

	logic                   carryIn;    // subtracted borrow
	logic [`LANE_WIDTH-1:0] diff;
	logic                   overflow;
	logic                   zeroPrefix; // cheap zero, CI = 0 only
	logic                   carryOut;
	logic                   zero;

	assign carryIn = laneIn.chained & borrowIn; // packed lanes stay isolated

	subVZ #(
		.width(`LANE_WIDTH),
		.speed(speed)
	) sub0 (
		.A (laneIn.a),
		.B (laneIn.b),
		.CI(carryIn),
		.S (diff),
		.V (overflow),
		.Z (zeroPrefix),
		.CO(carryOut)
	);

	assign borrowOut = ~carryOut;
	assign zero = carryIn ? ~|diff : zeroPrefix; // full nor when a borrow comes in

	// lane result register, payload only
	always_ff @(posedge clk) begin
		laneOut.diff <= diff;
		laneOut.overflow <= overflow;
		laneOut.zero <= zero;
		laneOut.borrow <= borrowOut;
	end

	// the A == B shortcut inside the prefix tree must match the real difference
	zeroMatch: assert property (@(posedge clk) disable iff (reset)
		!carryIn |-> (zeroPrefix == ~|diff));

endmodule

// File: verilog/flagCollector.sv
// last pipeline stage, merges lane results into packed or wide flags and registers them
`timescale 1ns/1ps
`include "simdSub_params.svh"

module flagCollector (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   stageValid,
	input  simdSubPkg::subOp_e                     stageOp,
	input  simdSubPkg::laneOut_t [`LANE_COUNT-1:0] laneOut,
	output logic                                   resultValid,
	output simdSubPkg::subResult_t                 result
);

	logic                   validD; // lines up with lane registers
	simdSubPkg::subOp_e     opD;
	simdSubPkg::subResult_t merged;

	always_ff @(posedge clk) begin
		if (reset) begin
			validD <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			validD <= stageValid;
			resultValid <= validD;
		end
	end

	always_ff @(posedge clk) begin
		opD <= stageOp;
		result <= merged;
	end

	always_comb begin
		for (int i = 0; i < `LANE_COUNT; i++) begin
			merged.diff[i*`LANE_WIDTH +: `LANE_WIDTH] = laneOut[i].diff;
			merged.laneOverflow[i] = laneOut[i].overflow; // raw in every mode
			merged.laneZero[i] = laneOut[i].zero;
		end
		// top lane holds the word msb in wide mode
		merged.overflow = laneOut[`LANE_COUNT-1].overflow;
		merged.borrowOut = laneOut[`LANE_COUNT-1].borrow;
		merged.zero = (opD == simdSubPkg::SUB_PACKED) ? laneOut[`LANE_COUNT-1].zero
			: &merged.laneZero; // word zero only if every lane is
	end

	// strobe is consumed without handshake downstream
	validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(resultValid));

endmodule

// File: verilog/simdSubtractor.sv
// packed-lane subtractor top, three-stage pipeline taking one request per cycle
`timescale 1ns/1ps
`include "simdSub_params.svh"

module simdSubtractor #(
	parameter lauPkg::speed_e prefixSpeed = lauPkg::FAST // lane prefix structure
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   reqValid,    // one-cycle strobe
	input  simdSubPkg::subReq_t    req,
	output logic                   resultValid, // 3 cycles after reqValid
	output simdSubPkg::subResult_t result
);

	simdSubPkg::laneIn_t  [`LANE_COUNT-1:0] laneIn;
	simdSubPkg::laneOut_t [`LANE_COUNT-1:0] laneOut;
	logic                 [`LANE_COUNT-1:0] laneBorrow; // borrow into each lane
	logic                                   firstBorrow;
	logic                                   stageValid;
	simdSubPkg::subOp_e                     stageOp;

	assign laneBorrow[0] = firstBorrow;

	operandSplitter split0 (
		.clk, .reset, .reqValid, .req,
		.laneIn, .firstBorrow, .stageValid, .stageOp
	);

	// borrow ripples through all lanes inside stage 2
	for (genvar i = 0; i < `LANE_COUNT; i++) begin : lanes
		if (i < `LANE_COUNT - 1) begin : chainLane
			subLane #(.speed(prefixSpeed)) lane0 (
				.clk, .reset, .laneIn(laneIn[i]), .borrowIn(laneBorrow[i]),
				.borrowOut(laneBorrow[i+1]), .laneOut(laneOut[i])
			);
		end else begin : topLane
			// word borrow leaves through the lane register
			subLane #(.speed(prefixSpeed)) lane0 (
				.clk, .reset, .laneIn(laneIn[i]), .borrowIn(laneBorrow[i]),
				.borrowOut(), .laneOut(laneOut[i])
			);
		end
	end

	flagCollector coll0 (
		.clk, .reset, .stageValid, .stageOp,
		.laneOut, .resultValid, .result
	);

endmodule

// File: sim/simdSubTb.sv
// testbench for simdSubtractor, random and directed requests checked against a reference model
`timescale 1ns/1ps
`include "simdSub_params.svh"

module simdSubTb;

	// request as sent, tagged with the cycle it is driven in
	typedef struct packed {
		simdSubPkg::subReq_t req;
		int                  tag;
	} pendingReq_t;

	logic                   clk;
	logic                   reset;
	logic                   reqValid;
	simdSubPkg::subReq_t    req;
	logic                   resultValid;
	simdSubPkg::subResult_t result;

	pendingReq_t pending[$]; // in flight, oldest first
	int          cycleCount;
	int          sentCount;
	int          checkedCount;
	logic [31:0] rngState;

	simdSubtractor #(.prefixSpeed(lauPkg::FAST)) dut0 (
		.clk, .reset, .reqValid, .req, .resultValid, .result
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// expected output from plain integer arithmetic
	function automatic simdSubPkg::subResult_t expectedResult(input simdSubPkg::subReq_t r);
		simdSubPkg::subResult_t e;
		logic                   wide;
		int                     borrowI; // borrow into current lane
		int                     ua;
		int                     ub;
		int                     sa;
		int                     sb;
		int                     ld;
		int                     sd;
		int                     half;
		logic                   topBorrow;
		longint                 wd;
		longint                 ws;
		longint                 wordHalf;
		e = '0;
		half = 1 << (`LANE_WIDTH - 1);
		wordHalf = longint'(1) << (`WORD_WIDTH - 1);
		wide = (r.op != simdSubPkg::SUB_PACKED);
		borrowI = (r.op == simdSubPkg::SBB_WIDE && r.borrowIn) ? 1 : 0;
		topBorrow = 1'b0;
		for (int i = 0; i < `LANE_COUNT; i++) begin
			ua = int'(r.a[i*`LANE_WIDTH +: `LANE_WIDTH]);
			ub = int'(r.b[i*`LANE_WIDTH +: `LANE_WIDTH]);
			sa = (ua >= half) ? ua - 2 * half : ua; // signed lane view
			sb = (ub >= half) ? ub - 2 * half : ub;
			ld = ua - ub - borrowI;
			sd = sa - sb - borrowI;
			e.diff[i*`LANE_WIDTH +: `LANE_WIDTH] = ld[`LANE_WIDTH-1:0];
			e.laneOverflow[i] = (sd < -half) || (sd >= half);
			e.laneZero[i] = (ld[`LANE_WIDTH-1:0] == '0);
			topBorrow = (ld < 0);
			borrowI = (wide && ld < 0) ? 1 : 0; // ripples only in wide modes
		end
		if (wide) begin
			borrowI = (r.op == simdSubPkg::SBB_WIDE && r.borrowIn) ? 1 : 0;
			wd = longint'(r.a) - longint'(r.b) - longint'(borrowI);
			ws = longint'($signed(r.a)) - longint'($signed(r.b)) - longint'(borrowI);
			e.diff = wd[`WORD_WIDTH-1:0]; // whole word, not lane concat
			e.overflow = (ws < -wordHalf) || (ws >= wordHalf);
			e.borrowOut = (wd < 0);
			e.zero = (wd[`WORD_WIDTH-1:0] == '0);
		end else begin
			e.overflow = e.laneOverflow[`LANE_COUNT-1]; // top lane stands in
			e.zero = e.laneZero[`LANE_COUNT-1];
			e.borrowOut = topBorrow;
		end
		return e;
	endfunction

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			stopWithFailure($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
				$time, name, got, exp));
		end
	endtask

	// one request, held for a single cycle unless another follows
	task automatic sendReq(input simdSubPkg::subOp_e op, input logic [31:0] a,
		input logic [31:0] b, input logic borrowIn);
		pendingReq_t entry;
		@(posedge clk);
		#1;
		req.op = op;
		req.a = a;
		req.b = b;
		req.borrowIn = borrowIn;
		reqValid = 1'b1;
		entry.req = req;
		entry.tag = cycleCount; // driven in this cycle
		pending.push_back(entry);
		sentCount++;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			reqValid = 1'b0;
		end
	endtask

	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		while (pending.size() != 0) begin
			if (n >= limit) begin
				stopWithFailure($sformatf("timeout: %0d results still missing after %0d cycles",
					pending.size(), limit));
			end
			@(posedge clk);
			#1;
			reqValid = 1'b0;
			n++;
		end
	endtask

	// scoreboard, samples on the falling edge
	initial begin : compare
		pendingReq_t            entry;
		simdSubPkg::subResult_t exp;
		forever begin
			@(negedge clk);
			if (reset) begin
				if (cycleCount >= 1) begin
					checkValue("resultValid", 64'(resultValid), 64'(0)); // quiet in reset
				end
			end else if (resultValid === 1'b1) begin
				if (pending.size() == 0) begin
					stopWithFailure("result strobe seen with no request outstanding");
				end
				entry = pending.pop_front();
				exp = expectedResult(entry.req);
				checkValue("latency", 64'(cycleCount - entry.tag), 64'(3));
				checkValue("diff", 64'(result.diff), 64'(exp.diff));
				checkValue("laneOverflow", 64'(result.laneOverflow), 64'(exp.laneOverflow));
				checkValue("laneZero", 64'(result.laneZero), 64'(exp.laneZero));
				checkValue("overflow", 64'(result.overflow), 64'(exp.overflow));
				checkValue("zero", 64'(result.zero), 64'(exp.zero));
				checkValue("borrowOut", 64'(result.borrowOut), 64'(exp.borrowOut));
				checkedCount++;
			end else begin
				checkValue("resultValid", 64'(resultValid), 64'(0)); // no X after reset
			end
		end
	end

	initial begin : stimulus
		logic [31:0] a;
		simdSubPkg::subOp_e op;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		cycleCount = 0;
		sentCount = 0;
		checkedCount = 0;
		rngState = 32'd51;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		idleCycles(6); // nothing may come out

		sendReq(simdSubPkg::SUB_PACKED, 32'h12345678, 32'h12345678, 1'b0); // all lanes zero
		sendReq(simdSubPkg::SUB_PACKED, 32'h80808080, 32'h01010101, 1'b0); // min minus one
		sendReq(simdSubPkg::SUB_PACKED, 32'h7f7f7f7f, 32'hffffffff, 1'b0); // max minus -1
		sendReq(simdSubPkg::SUB_PACKED, 32'h00ff0000, 32'h01000001, 1'b1); // borrow must not leak
		for (int i = 0; i < 200; i++) begin
			sendReq(simdSubPkg::SUB_PACKED, nextRandom(), nextRandom(), 1'(nextRandom() & 1));
		end
		waitDrain(20);

		sendReq(simdSubPkg::SUB_WIDE, 32'hdeadbeef, 32'hdeadbeef, 1'b0);
		sendReq(simdSubPkg::SUB_WIDE, 32'h80000000, 32'h00000001, 1'b0); // MIN-1 overflows
		sendReq(simdSubPkg::SUB_WIDE, 32'h00000000, 32'h00000001, 1'b1); // ripple through all lanes
		sendReq(simdSubPkg::SUB_WIDE, 32'h01000000, 32'h00000001, 1'b0);
		for (int i = 0; i < 100; i++) begin
			a = nextRandom();
			sendReq(simdSubPkg::SUB_WIDE, a, (i % 4 == 0) ? a ^ (nextRandom() & 32'hff) :
				nextRandom(), 1'b0);
		end
		waitDrain(20);

		sendReq(simdSubPkg::SBB_WIDE, 32'h12345679, 32'h12345678, 1'b1); // lands on zero
		sendReq(simdSubPkg::SBB_WIDE, 32'h55aa55aa, 32'h55aa55aa, 1'b1); // all ones, borrow out
		sendReq(simdSubPkg::SBB_WIDE, 32'h00000000, 32'h00000000, 1'b0);
		for (int i = 0; i < 100; i++) begin
			sendReq(simdSubPkg::SBB_WIDE, nextRandom(), nextRandom(), 1'(nextRandom() & 1));
		end
		waitDrain(20);

		// mixed stream, sometimes back to back, sometimes with gaps
		for (int i = 0; i < 300; i++) begin
			op = simdSubPkg::subOp_e'(2'(nextRandom() % 3));
			sendReq(op, nextRandom(), nextRandom(), 1'(nextRandom() & 1));
			if (nextRandom() % 4 == 0) begin
				idleCycles(1 + nextRandom() % 3);
			end
		end
		waitDrain(20);
		idleCycles(4);

		if (pending.size() == 0 && checkedCount == sentCount && sentCount > 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stopWithFailure($sformatf("run ended with %0d of %0d results checked",
				checkedCount, sentCount));
		end
	end

endmodule

// File: project.f
+incdir+verilog
verilog/lauPkg.sv
verilog/simdSubPkg.sv
verilog/prefixAndOr.sv
verilog/subVZ.sv
verilog/operandSplitter.sv
verilog/subLane.sv
verilog/flagCollector.sv
verilog/simdSubtractor.sv
sim/simdSubTb.sv

// File: Makefile
# Verilator flow for the packed-lane subtractor; a failing run exits non-zero
TB  := simdSubTb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module simdSubtractor -f project.f
	verilator --lint-only --timing --assert --top-module $(TB) -f project.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB) -f project.f \
		--Mdir $(OBJ) -o $(TB)
	./$(OBJ)/$(TB)

clean:
	rm -rf $(OBJ)
